// File: source/soc_pkg.sv
/*
 * soc_pkg: bus structs, width types, address map and
 * system controller register layout shared by the slice
 */
package soc_pkg;

	// --------------------------------------------------
	// width types
	typedef logic [31:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [3:0]  wb_sel_t;
	// word address, byte address bits 15..2
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] gpio_in_t;
	typedef logic [3:0]  led_t;
	typedef logic [31:0] irq_vec_t;

	// --------------------------------------------------
	// bus structs
	// master side of wishbone classic
	typedef struct packed {
		wb_addr_t adr;
		wb_data_t dat;
		wb_sel_t  sel;
		logic     we;
		logic     cyc;
		logic     stb;
	} wb_req_t;

	// slave side, one of ack/err per access
	typedef struct packed {
		wb_data_t dat;
		logic     ack;
		logic     err;
	} wb_rsp_t;

	// csr bus, no handshake
	typedef struct packed {
		csr_addr_t a;
		logic      we;
		wb_data_t  dat;
	} csr_req_t;

	typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} csrbrg_state_t;

	// --------------------------------------------------
	// address map, bit 31 not decoded
	localparam logic [2:0] REGION_RAM  = 3'b000;
	localparam logic [1:0] REGION_CSR  = 2'b11;
	localparam logic [3:0] SYSCTL_BANK = 4'h1;

	// sysctl word offsets within the bank
	localparam logic [9:0] REG_GPIO_IN       = 10'd0;
	localparam logic [9:0] REG_LEDS          = 10'd1;
	localparam logic [9:0] REG_GPIO_MASK     = 10'd2;
	localparam logic [9:0] REG_TIMER_CTRL    = 10'd3;
	localparam logic [9:0] REG_TIMER_COMPARE = 10'd4;
	localparam logic [9:0] REG_TIMER_COUNTER = 10'd5;
	localparam logic [9:0] REG_SYSTEM_ID     = 10'd6;

	// timer control bits
	localparam int TIMER_EN_BIT = 0;
	localparam int TIMER_AR_BIT = 1;

	// 1.3.0 final on M1
	localparam wb_data_t SYSTEM_ID = 32'h13004D31;

	// interrupt vector positions
	localparam int IRQ_GPIO   = 1;
	localparam int IRQ_TIMER0 = 2;

endpackage

// File: source/reset_gen.sv
/*
 * reset_gen: stretches the reset trigger into a held system reset
 */
`timescale 1ns/1ns

module reset_gen #(
	parameter int RESET_HOLD = 16
) (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	// loaded at power-on, so the slice starts in reset
	logic [CNT_W-1:0] hold_cnt_q = CNT_W'(RESET_HOLD);

	// reload while the trigger is high, count down after it drops
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			hold_cnt_q <= CNT_W'(RESET_HOLD);
		end else if (hold_cnt_q != '0) begin
			hold_cnt_q <= hold_cnt_q - 1'b1;
		end
	end

	// held until the count runs out
	assign sys_rst_o = hold_cnt_q != '0;

endmodule

// File: source/wb_decoder.sv
/*
 * wb_decoder: address decode, response mux and error
 * responder for accesses to unmapped space
 */
`timescale 1ns/1ns

module wb_decoder (
	input  logic             sys_clk,
	input  logic             sys_rst_i,
	input  soc_pkg::wb_req_t wb_i,
	output soc_pkg::wb_rsp_t wb_o,
	output soc_pkg::wb_req_t ram_req_o,
	input  soc_pkg::wb_rsp_t ram_rsp_i,
	output soc_pkg::wb_req_t csr_req_o,
	input  soc_pkg::wb_rsp_t csr_rsp_i
);

	logic ram_sel;
	logic csr_sel;
	logic unmapped_access;
	logic err_q;

	// bit 31 ignored so the upper half shadows the lower
	assign ram_sel = wb_i.adr[30:28] == soc_pkg::REGION_RAM;
	assign csr_sel = wb_i.adr[30:29] == soc_pkg::REGION_CSR;
	assign unmapped_access = wb_i.cyc & wb_i.stb & ~ram_sel & ~csr_sel;

	// strobe reaches the selected slave only
	always_comb begin
		ram_req_o     = wb_i;
		ram_req_o.cyc = wb_i.cyc & ram_sel;
		ram_req_o.stb = wb_i.stb & ram_sel;
		csr_req_o     = wb_i;
		csr_req_o.cyc = wb_i.cyc & csr_sel;
		csr_req_o.stb = wb_i.stb & csr_sel;
	end

	// --------------------------------------------------
	// error responder answers once per held strobe
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= unmapped_access & ~err_q;
		end
	end

	// response back from whichever slave is addressed
	always_comb begin
		wb_o.dat = '0;
		wb_o.ack = 1'b0;
		wb_o.err = err_q;
		if (ram_sel) begin
			wb_o = ram_rsp_i;
		end else if (csr_sel) begin
			wb_o = csr_rsp_i;
		end
	end

	// at most one slave answers in any cycle
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		$onehot0({ram_rsp_i.ack, csr_rsp_i.ack, err_q}))
		else $error("wb_decoder: ack and err high together");

endmodule

// File: source/bram_slave.sv
/*
 * bram_slave: on-chip word RAM on the wishbone bus,
 * byte-lane writes and single-cycle ack
 */
`timescale 1ns/1ns

module bram_slave #(
	parameter int RAM_ADDR_WIDTH = 8
) (
	input  logic             sys_clk,
	input  logic             sys_rst_i,
	input  soc_pkg::wb_req_t wb_i,
	output soc_pkg::wb_rsp_t wb_o
);

	localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

	soc_pkg::wb_data_t         mem [DEPTH];
	soc_pkg::wb_data_t         rdata_q;
	logic [RAM_ADDR_WIDTH-1:0] word_idx;
	logic                      ack_q;
	logic                      access;

	// word index, byte offset dropped
	assign word_idx = wb_i.adr[RAM_ADDR_WIDTH+1:2];
	// no new access in the ack cycle while stb is still up
	assign access = wb_i.cyc & wb_i.stb & ~ack_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// memory array, selected lanes only
	always_ff @(posedge sys_clk) begin
		if (access & wb_i.we & ~sys_rst_i) begin
			for (int i = 0; i < 4; i++) begin
				if (wb_i.sel[i]) begin
					mem[word_idx][i*8 +: 8] <= wb_i.dat[i*8 +: 8];
				end
			end
		end
		rdata_q <= mem[word_idx];
	end

	assign wb_o.dat = rdata_q;
	assign wb_o.ack = ack_q;
	assign wb_o.err = 1'b0;

endmodule

// File: source/wb_csr_bridge.sv
/*
 * wb_csr_bridge: one single-cycle CSR access for each
 * wishbone access, read data registered for the ack
 */
`timescale 1ns/1ns

module wb_csr_bridge (
	input  logic              sys_clk,
	input  logic              sys_rst_i,
	input  soc_pkg::wb_req_t  wb_i,
	output soc_pkg::wb_rsp_t  wb_o,
	output soc_pkg::csr_req_t csr_o,
	input  soc_pkg::wb_data_t csr_rdata_i
);

	soc_pkg::csrbrg_state_t state_q;
	soc_pkg::csr_req_t      csr_q;
	soc_pkg::wb_data_t      rdata_q;
	logic                   strobe;

	assign strobe = wb_i.cyc & wb_i.stb;

	always_ff @(posedge sys_clk) begin
		// address and write data taken with the strobe
		if (state_q == soc_pkg::IDLE && strobe) begin
			csr_q.a   <= wb_i.adr[15:2];
			csr_q.dat <= wb_i.dat;
		end
		// slave answers combinationally during ACCESS
		if (state_q == soc_pkg::ACCESS) begin
			rdata_q <= csr_rdata_i;
		end

		if (sys_rst_i) begin
			state_q  <= soc_pkg::IDLE;
			csr_q.we <= 1'b0;
		end else begin
			// write pulse lasts one cycle
			csr_q.we <= 1'b0;
			case (state_q)
				soc_pkg::IDLE: begin
					if (strobe) begin
						state_q  <= soc_pkg::ACCESS;
						csr_q.we <= wb_i.we;
					end
				end
				soc_pkg::ACCESS: state_q <= soc_pkg::RESPOND;
				// stb still high here, dropped by the master after ack
				soc_pkg::RESPOND: state_q <= soc_pkg::IDLE;
				default: state_q <= soc_pkg::IDLE;
			endcase
		end
	end

	assign csr_o    = csr_q;
	assign wb_o.dat = rdata_q;
	assign wb_o.ack = state_q == soc_pkg::RESPOND;
	assign wb_o.err = 1'b0;

	// exactly one csr write per wishbone write
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		csr_o.we |-> state_q == soc_pkg::ACCESS)
		else $error("wb_csr_bridge: csr we outside ACCESS");

endmodule

// File: source/sysctl.sv
/*
 * sysctl: GPIO inputs, LEDs, GPIO change interrupt, one
 * programmable timer and the system identifier on the CSR bus
 */
`timescale 1ns/1ns

module sysctl (
	input  logic              sys_clk,
	input  logic              sys_rst_i,
	input  soc_pkg::csr_req_t csr_i,
	output soc_pkg::wb_data_t csr_rdata_o,
	input  soc_pkg::gpio_in_t gpio_i,
	output soc_pkg::led_t     leds_o,
	output logic              gpio_irq_o,
	output logic              timer_irq_o
);

	logic              bank_sel;
	logic [9:0]        reg_off;
	logic              wr_en;
	soc_pkg::gpio_in_t gpio_s1;
	soc_pkg::gpio_in_t gpio_s2;
	soc_pkg::gpio_in_t gpio_prev;
	soc_pkg::gpio_in_t gpio_mask_q;
	soc_pkg::led_t     leds_q;
	logic              timer_en_q;
	logic              timer_ar_q;
	soc_pkg::wb_data_t compare_q;
	soc_pkg::wb_data_t counter_q;
	logic              gpio_irq_q;
	logic              timer_irq_q;

	// bank in bits 13..10, register in 9..0
	assign bank_sel = csr_i.a[13:10] == soc_pkg::SYSCTL_BANK;
	assign reg_off  = csr_i.a[9:0];
	assign wr_en    = bank_sel & csr_i.we;

	// two-flop sync, plus last value for edge detect
	always_ff @(posedge sys_clk) begin
		gpio_s1   <= gpio_i;
		gpio_s2   <= gpio_s1;
		gpio_prev <= gpio_s2;
	end

	// --------------------------------------------------
	// control registers and timer
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			leds_q      <= '0;
			gpio_mask_q <= '0;
			timer_en_q  <= 1'b0;
			timer_ar_q  <= 1'b0;
			compare_q   <= '0;
			counter_q   <= '0;
			gpio_irq_q  <= 1'b0;
			timer_irq_q <= 1'b0;
		end else begin
			// any masked bit toggled
			gpio_irq_q  <= |((gpio_s2 ^ gpio_prev) & gpio_mask_q);
			timer_irq_q <= 1'b0;
			if (timer_en_q) begin
				if (counter_q == compare_q) begin
					counter_q   <= '0;
					timer_irq_q <= 1'b1;
					// one-shot stops itself
					if (!timer_ar_q) begin
						timer_en_q <= 1'b0;
					end
				end else begin
					counter_q <= counter_q + 1'b1;
				end
			end
			// bus writes win over the count
			if (wr_en) begin
				case (reg_off)
					soc_pkg::REG_LEDS: leds_q <= csr_i.dat[$bits(soc_pkg::led_t)-1:0];
					soc_pkg::REG_GPIO_MASK: gpio_mask_q <= csr_i.dat;
					soc_pkg::REG_TIMER_CTRL: begin
						timer_en_q <= csr_i.dat[soc_pkg::TIMER_EN_BIT];
						timer_ar_q <= csr_i.dat[soc_pkg::TIMER_AR_BIT];
					end
					soc_pkg::REG_TIMER_COMPARE: compare_q <= csr_i.dat;
					soc_pkg::REG_TIMER_COUNTER: counter_q <= csr_i.dat;
					default: ;
				endcase
			end
		end
	end

	// read mux, zero outside the bank
	always_comb begin
		csr_rdata_o = '0;
		if (bank_sel) begin
			case (reg_off)
				soc_pkg::REG_GPIO_IN: csr_rdata_o = gpio_s2;
				soc_pkg::REG_LEDS: csr_rdata_o = 32'(leds_q);
				soc_pkg::REG_GPIO_MASK: csr_rdata_o = gpio_mask_q;
				soc_pkg::REG_TIMER_CTRL: begin
					csr_rdata_o[soc_pkg::TIMER_EN_BIT] = timer_en_q;
					csr_rdata_o[soc_pkg::TIMER_AR_BIT] = timer_ar_q;
				end
				soc_pkg::REG_TIMER_COMPARE: csr_rdata_o = compare_q;
				soc_pkg::REG_TIMER_COUNTER: csr_rdata_o = counter_q;
				soc_pkg::REG_SYSTEM_ID: csr_rdata_o = soc_pkg::SYSTEM_ID;
				default: csr_rdata_o = '0;
			endcase
		end
	end

	assign leds_o      = leds_q;
	assign gpio_irq_o  = gpio_irq_q;
	assign timer_irq_o = timer_irq_q;

	// counter wraps at compare, never runs past it
	assert property (@(posedge sys_clk) disable iff (sys_rst_i)
		timer_en_q |-> counter_q <= compare_q)
		else $error("sysctl: timer counter above compare");

endmodule

// File: source/soc_top.sv
/*
 * soc_top: system bus slice with reset generator, decoder,
 * on-chip RAM, CSR bridge and system controller
 */
`timescale 1ns/1ns

module soc_top #(
	parameter int RESET_HOLD     = 16,
	parameter int RAM_ADDR_WIDTH = 8
) (
	input  logic              sys_clk,
	input  logic              trigger_reset,
	input  soc_pkg::wb_req_t  wb_i,
	output soc_pkg::wb_rsp_t  wb_o,
	input  soc_pkg::gpio_in_t gpio_i,
	output soc_pkg::led_t     leds_o,
	output soc_pkg::irq_vec_t irq_o,
	output logic              ready_o
);

	logic              sys_rst;
	soc_pkg::wb_req_t  ram_req;
	soc_pkg::wb_rsp_t  ram_rsp;
	soc_pkg::wb_req_t  brg_req;
	soc_pkg::wb_rsp_t  brg_rsp;
	soc_pkg::csr_req_t csr_req;
	soc_pkg::wb_data_t csr_rdata;
	logic              gpio_irq;
	logic              timer_irq;

	// --------------------------------------------------
	// reset
	reset_gen #(.RESET_HOLD(RESET_HOLD)) i_reset_gen (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.sys_rst_o(sys_rst)
	);
	assign ready_o = ~sys_rst;

	// --------------------------------------------------
	// wishbone side
	wb_decoder i_wb_decoder (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_i(wb_i),
		.wb_o(wb_o),
		.ram_req_o(ram_req),
		.ram_rsp_i(ram_rsp),
		.csr_req_o(brg_req),
		.csr_rsp_i(brg_rsp)
	);

	bram_slave #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_bram_slave (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_i(ram_req),
		.wb_o(ram_rsp)
	);

	// single csr slave, no read-data OR needed
	wb_csr_bridge i_wb_csr_bridge (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.wb_i(brg_req),
		.wb_o(brg_rsp),
		.csr_o(csr_req),
		.csr_rdata_i(csr_rdata)
	);

	sysctl i_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_i(csr_req),
		.csr_rdata_o(csr_rdata),
		.gpio_i(gpio_i),
		.leds_o(leds_o),
		.gpio_irq_o(gpio_irq),
		.timer_irq_o(timer_irq)
	);

	// interrupt vector, unused lines tied low
	always_comb begin
		irq_o                      = '0;
		irq_o[soc_pkg::IRQ_GPIO]   = gpio_irq;
		irq_o[soc_pkg::IRQ_TIMER0] = timer_irq;
	end

endmodule

// File: verification/soc_checker.sv
/*
 * soc_checker: watches the DUT ports, compares bus responses,
 * LEDs and interrupt pulses with the current stimulus row
 */
`timescale 1ns/1ns

module soc_checker #(
	parameter int RESET_HOLD = 16
) (
	input  logic              sys_clk,
	input  logic              trigger_reset,
	input  soc_pkg::wb_req_t  wb_req_i,
	input  soc_pkg::wb_rsp_t  wb_rsp_i,
	input  soc_pkg::led_t     leds_i,
	input  soc_pkg::irq_vec_t irq_i,
	input  logic              ready_i,
	input  int                row_idx_i,
	input  soc_pkg::wb_data_t row_wdata_i,
	input  soc_pkg::wb_data_t row_exp_dat_i,
	input  logic              row_chk_dat_i,
	input  logic              row_exp_err_i,
	input  soc_pkg::led_t     row_exp_leds_i,
	input  logic              irq_chk_i,
	output int                value_errs_o,
	output int                fault_errs_o
);

	// cycles a strobe may wait before it counts as lost
	localparam int STALL_LIMIT = 32;
	localparam soc_pkg::irq_vec_t IRQ_USED =
		(32'd1 << soc_pkg::IRQ_GPIO) | (32'd1 << soc_pkg::IRQ_TIMER0);

	int value_errs = 0;
	int fault_errs = 0;
	int cycle_cnt = 0;
	int hold_cnt = 0;
	bit ready_seen = 1'b0;
	int gpio_pulses = 0;
	int timer_pulses = 0;
	int last_timer_cycle = 0;
	int timer_gap = 0;
	int stall_cnt = 0;

	assign value_errs_o = value_errs;
	assign fault_errs_o = fault_errs;

	task automatic report_mismatch(input string msg);
		value_errs++;
		$display("CHECK FAILED at %0t: row %0d: %s", $time, row_idx_i, msg);
	endtask

	task automatic report_fault(input string msg);
		fault_errs++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	// --------------------------------------------------
	// sampled on the falling edge
	always @(negedge sys_clk) begin
		cycle_cnt++;

		// outputs stay quiet until ready
		if (!ready_i) begin
			if (leds_i !== '0 || irq_i !== '0 ||
				wb_rsp_i.ack !== 1'b0 || wb_rsp_i.err !== 1'b0) begin
				report_mismatch("outputs active while ready is low");
			end
			if (!trigger_reset) begin
				hold_cnt++;
			end
		end else if (!ready_seen) begin
			ready_seen = 1'b1;
			if (hold_cnt != RESET_HOLD) begin
				report_mismatch($sformatf("reset held %0d cycles after trigger, expected %0d",
					hold_cnt, RESET_HOLD));
			end
		end

		// one count per cycle that an interrupt line is high
		if ((irq_i & ~IRQ_USED) !== '0) begin
			report_mismatch($sformatf("unused irq bits set: %h", irq_i));
		end
		if (irq_i[soc_pkg::IRQ_GPIO]) begin
			gpio_pulses++;
		end
		if (irq_i[soc_pkg::IRQ_TIMER0]) begin
			timer_gap = cycle_cnt - last_timer_cycle;
			last_timer_cycle = cycle_cnt;
			timer_pulses++;
		end

		// bus response against the row
		if (wb_rsp_i.ack || wb_rsp_i.err) begin
			stall_cnt = 0;
			if (!(wb_req_i.cyc && wb_req_i.stb)) begin
				report_fault("bus response seen with no access in progress");
			end else if (wb_rsp_i.ack && wb_rsp_i.err) begin
				report_mismatch("ack and err high together");
			end else if (row_exp_err_i && !wb_rsp_i.err) begin
				report_mismatch("expected err, got ack");
			end else if (!row_exp_err_i && !wb_rsp_i.ack) begin
				report_mismatch("expected ack, got err");
			end else if (row_chk_dat_i && wb_rsp_i.dat !== row_exp_dat_i) begin
				report_mismatch($sformatf("read %h, expected %h", wb_rsp_i.dat, row_exp_dat_i));
			end
			if (leds_i !== row_exp_leds_i) begin
				report_mismatch($sformatf("leds %h, expected %h", leds_i, row_exp_leds_i));
			end
		end else if (wb_req_i.cyc && wb_req_i.stb && ready_i) begin
			stall_cnt++;
			if (stall_cnt == STALL_LIMIT) begin
				report_fault($sformatf("no ack or err for the bus access of row %0d", row_idx_i));
			end
		end

		// pulse counts so far with the gpio count in the upper half
		if (irq_chk_i) begin
			if (gpio_pulses != int'(row_exp_dat_i[31:16])) begin
				report_mismatch($sformatf("%0d gpio irq pulses, expected %0d",
					gpio_pulses, row_exp_dat_i[31:16]));
			end
			if (timer_pulses != int'(row_exp_dat_i[15:0])) begin
				report_mismatch($sformatf("%0d timer irq pulses, expected %0d",
					timer_pulses, row_exp_dat_i[15:0]));
			end
			if (timer_pulses >= 2 && timer_gap < int'(row_wdata_i)) begin
				report_mismatch($sformatf("timer pulses %0d cycles apart, expected at least %0d",
					timer_gap, row_wdata_i));
			end
		end
	end

endmodule

// File: verification/tb_soc.sv
/*
 * tb_soc: clock, reset, stimulus table and bus master for
 * the system bus slice
 */
`timescale 1ns/1ns

module tb_soc;

	localparam int RESET_HOLD     = 16;
	localparam int RAM_ADDR_WIDTH = 8;
	localparam int RESET_CYCLES   = 4;
	localparam int ONESHOT_N      = 12;
	localparam int RELOAD_N       = 24;
	// two flops, edge detect, irq register, plus slack
	localparam int GPIO_SETTLE    = 6;
	localparam logic [31:0] SEED  = 32'he14b_936a;

	// row operations
	localparam logic [2:0] OP_WRITE = 3'd0;
	localparam logic [2:0] OP_READ  = 3'd1;
	localparam logic [2:0] OP_GPIO  = 3'd2;
	localparam logic [2:0] OP_WAIT  = 3'd3;
	localparam logic [2:0] OP_IRQS  = 3'd4;

	typedef struct packed {
		logic [2:0]        op;
		soc_pkg::wb_addr_t addr;
		soc_pkg::wb_data_t wdata;
		soc_pkg::wb_sel_t  sel;
		soc_pkg::wb_data_t exp_dat;
		logic              exp_err;
		soc_pkg::led_t     exp_leds;
	} stim_row_t;

	logic              sys_clk;
	logic              trigger_reset;
	soc_pkg::wb_req_t  wb_req;
	soc_pkg::wb_rsp_t  wb_rsp;
	soc_pkg::gpio_in_t gpio;
	soc_pkg::led_t     leds;
	soc_pkg::irq_vec_t irq;
	logic              ready;

	// current row as seen by the checker
	int                row_idx;
	soc_pkg::wb_data_t row_wdata;
	soc_pkg::wb_data_t row_exp_dat;
	logic              row_chk_dat;
	logic              row_exp_err;
	soc_pkg::led_t     row_exp_leds;
	logic              irq_chk;

	stim_row_t         table_q[$];
	soc_pkg::led_t     led_model;
	int                limit_cycles;
	int                value_errs;
	int                fault_errs;

	soc_top #(
		.RESET_HOLD(RESET_HOLD),
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
	) i_soc_top (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_i(wb_req),
		.wb_o(wb_rsp),
		.gpio_i(gpio),
		.leds_o(leds),
		.irq_o(irq),
		.ready_o(ready)
	);

	soc_checker #(.RESET_HOLD(RESET_HOLD)) i_soc_checker (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_req_i(wb_req),
		.wb_rsp_i(wb_rsp),
		.leds_i(leds),
		.irq_i(irq),
		.ready_i(ready),
		.row_idx_i(row_idx),
		.row_wdata_i(row_wdata),
		.row_exp_dat_i(row_exp_dat),
		.row_chk_dat_i(row_chk_dat),
		.row_exp_err_i(row_exp_err),
		.row_exp_leds_i(row_exp_leds),
		.irq_chk_i(irq_chk),
		.value_errs_o(value_errs),
		.fault_errs_o(fault_errs)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// --------------------------------------------------
	// table helpers
	// csr region, bank on byte bits 15..12, word offset below
	function automatic soc_pkg::wb_addr_t csr_byte_addr(input logic [3:0] bank,
		input logic [9:0] off);
		return {1'b0, soc_pkg::REGION_CSR, 13'd0, bank, off, 2'b00};
	endfunction

	// word after a write with byte selects
	function automatic soc_pkg::wb_data_t merge_lanes(input soc_pkg::wb_data_t old_w,
		input soc_pkg::wb_data_t new_w, input soc_pkg::wb_sel_t sel);
		soc_pkg::wb_data_t res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = new_w[i*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic add_row(input logic [2:0] op, input soc_pkg::wb_addr_t addr,
		input soc_pkg::wb_data_t wdata, input soc_pkg::wb_sel_t sel,
		input soc_pkg::wb_data_t exp_dat, input logic exp_err);
		stim_row_t row;
		row.op       = op;
		row.addr     = addr;
		row.wdata    = wdata;
		row.sel      = sel;
		row.exp_dat  = exp_dat;
		row.exp_err  = exp_err;
		row.exp_leds = led_model;
		table_q.push_back(row);
	endtask

	task automatic build_table();
		soc_pkg::wb_data_t r [7];
		soc_pkg::wb_addr_t leds_a;
		soc_pkg::wb_addr_t ctrl_a;
		soc_pkg::gpio_in_t g;
		foreach (r[i]) begin
			r[i] = $urandom();
		end
		leds_a = csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_LEDS);
		ctrl_a = csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_CTRL);
		g = r[4];
		led_model = '0;
		// ram, full words, byte lanes, bit 31 shadow
		add_row(OP_WRITE, 32'h0000_0010, r[0], 4'hF, '0, 1'b0);
		add_row(OP_WRITE, 32'h0000_0014, r[1], 4'hF, '0, 1'b0);
		add_row(OP_READ, 32'h0000_0010, '0, 4'hF, r[0], 1'b0);
		add_row(OP_READ, 32'h0000_0014, '0, 4'hF, r[1], 1'b0);
		add_row(OP_WRITE, 32'h0000_0010, r[2], 4'b0101, '0, 1'b0);
		add_row(OP_READ, 32'h0000_0010, '0, 4'hF, merge_lanes(r[0], r[2], 4'b0101), 1'b0);
		add_row(OP_WRITE, 32'h8000_0040, r[3], 4'hF, '0, 1'b0);
		add_row(OP_READ, 32'h0000_0040, '0, 4'hF, r[3], 1'b0);
		add_row(OP_WRITE, 32'h0000_0080, r[6], 4'hF, '0, 1'b0);
		add_row(OP_READ, 32'h8000_0080, '0, 4'hF, r[6], 1'b0);
		// unmapped space and a foreign csr bank
		add_row(OP_WRITE, 32'h2000_0000, r[0], 4'hF, '0, 1'b1);
		add_row(OP_READ, 32'h4000_0004, '0, 4'hF, '0, 1'b1);
		add_row(OP_READ, 32'hD000_0000, '0, 4'hF, '0, 1'b1);
		add_row(OP_READ, csr_byte_addr(4'h2, 10'd0), '0, 4'hF, '0, 1'b0);
		// sysctl registers
		add_row(OP_READ, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_SYSTEM_ID),
			'0, 4'hF, soc_pkg::SYSTEM_ID, 1'b0);
		add_row(OP_READ, 32'hE000_1018, '0, 4'hF, soc_pkg::SYSTEM_ID, 1'b0);
		led_model = {r[5][3:1], 1'b1};
		add_row(OP_WRITE, leds_a, r[5] | 32'h1, 4'hF, '0, 1'b0);
		add_row(OP_READ, leds_a, '0, 4'hF, 32'(led_model), 1'b0);
		// gpio input and change interrupt on bit 4 only
		add_row(OP_GPIO, '0, g, '0, '0, 1'b0);
		add_row(OP_READ, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IN),
			'0, 4'hF, g, 1'b0);
		add_row(OP_WRITE, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_MASK),
			32'h0000_0010, 4'hF, '0, 1'b0);
		add_row(OP_GPIO, '0, g ^ 32'h0000_0010, '0, '0, 1'b0);
		add_row(OP_GPIO, '0, g ^ 32'h0000_0110, '0, '0, 1'b0);
		add_row(OP_IRQS, '0, '0, '0, {16'd1, 16'd0}, 1'b0);
		add_row(OP_READ, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_GPIO_IN),
			'0, 4'hF, g ^ 32'h0000_0110, 1'b0);
		// one-shot timer, stops and clears itself
		add_row(OP_WRITE, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COMPARE),
			ONESHOT_N, 4'hF, '0, 1'b0);
		add_row(OP_WRITE, ctrl_a, 32'h1, 4'hF, '0, 1'b0);
		add_row(OP_WAIT, '0, 2 * ONESHOT_N + 6, '0, '0, 1'b0);
		add_row(OP_IRQS, '0, '0, '0, {16'd1, 16'd1}, 1'b0);
		add_row(OP_READ, ctrl_a, '0, 4'hF, '0, 1'b0);
		add_row(OP_READ, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COUNTER),
			'0, 4'hF, '0, 1'b0);
		// autoreload, stopped between the second and third pulse
		add_row(OP_WRITE, csr_byte_addr(soc_pkg::SYSCTL_BANK, soc_pkg::REG_TIMER_COMPARE),
			RELOAD_N, 4'hF, '0, 1'b0);
		add_row(OP_WRITE, ctrl_a, 32'h3, 4'hF, '0, 1'b0);
		add_row(OP_WAIT, '0, (5 * (RELOAD_N + 1)) / 2 - 5, '0, '0, 1'b0);
		add_row(OP_WRITE, ctrl_a, 32'h0, 4'hF, '0, 1'b0);
		add_row(OP_IRQS, '0, RELOAD_N, '0, {16'd1, 16'd3}, 1'b0);
		add_row(OP_READ, ctrl_a, '0, 4'hF, '0, 1'b0);
	endtask

	// --------------------------------------------------
	// bus master and row sequencing
	task automatic run_row(input stim_row_t row, input int idx);
		@(posedge sys_clk);
		row_idx      <= idx;
		row_wdata    <= row.wdata;
		row_exp_dat  <= row.exp_dat;
		row_chk_dat  <= (row.op == OP_READ) && !row.exp_err;
		row_exp_err  <= row.exp_err;
		row_exp_leds <= row.exp_leds;
		case (row.op)
			OP_WRITE, OP_READ: begin
				wb_req.adr <= row.addr;
				wb_req.dat <= row.wdata;
				wb_req.sel <= row.sel;
				wb_req.we  <= row.op == OP_WRITE;
				wb_req.cyc <= 1'b1;
				wb_req.stb <= 1'b1;
				// request held until the slave answers
				do begin
					@(negedge sys_clk);
				end while (!(wb_rsp.ack || wb_rsp.err));
				@(posedge sys_clk);
				wb_req.cyc <= 1'b0;
				wb_req.stb <= 1'b0;
			end
			OP_GPIO: begin
				gpio <= row.wdata;
				repeat (GPIO_SETTLE) @(posedge sys_clk);
			end
			OP_WAIT: repeat (row.wdata) @(posedge sys_clk);
			OP_IRQS: begin
				irq_chk <= 1'b1;
				@(posedge sys_clk);
				irq_chk <= 1'b0;
			end
			default: ;
		endcase
	endtask

	task automatic print_error_counts();
		$display("error counts: %0d wrong values, %0d other failures", value_errs, fault_errs);
	endtask

	initial begin
		trigger_reset = 1'b1;
		wb_req        = '0;
		gpio          = '0;
		row_idx       = 0;
		row_wdata     = '0;
		row_exp_dat   = '0;
		row_chk_dat   = 1'b0;
		row_exp_err   = 1'b0;
		row_exp_leds  = '0;
		irq_chk       = 1'b0;
		limit_cycles  = 0;
		void'($urandom(SEED));
		build_table();
		// 40 per row, reset, two reload periods, margin
		limit_cycles = table_q.size() * 40 + RESET_CYCLES + RESET_HOLD + 2 * RELOAD_N + 200;

		repeat (RESET_CYCLES) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		while (!ready) begin
			@(negedge sys_clk);
		end
		foreach (table_q[i]) begin
			run_row(table_q[i], i);
		end
		repeat (4) @(posedge sys_clk);

		print_error_counts();
		if (value_errs == 0 && fault_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// run limit
	initial begin : watchdog
		int cycles = 0;
		wait (limit_cycles != 0);
		while (cycles < limit_cycles) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		print_error_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: sources.f
source/soc_pkg.sv
source/reset_gen.sv
source/wb_decoder.sv
source/bram_slave.sv
source/wb_csr_bridge.sv
source/sysctl.sv
source/soc_top.sv
verification/soc_checker.sv
verification/tb_soc.sv

// File: Bender.yml
package:
  name: soc_slice

dependencies: {}

sources:
  - source/soc_pkg.sv
  - source/reset_gen.sv
  - source/wb_decoder.sv
  - source/bram_slave.sv
  - source/wb_csr_bridge.sv
  - source/sysctl.sv
  - source/soc_top.sv
  - target: simulation
    files:
      - verification/soc_checker.sv
      - verification/tb_soc.sv
